// File: rtl/coeff_pkg.sv
`default_nettype none

package coeff_pkg;

    localparam int SAMPLE_W = 32;  // phase in upper half, magnitude in lower half
    localparam int HALF_W   = 16;
    localparam int ACC_W    = 32;
    localparam int CNT_W    = 16;  // frame length and sample count

    localparam int NUM_CH  = 4;  // streams in, coefficients out
    // 0..3 carry phases then ratios, 4..7 carry the magnitudes a1 b1 a2 b2
    localparam int NUM_DIV = 8;

    typedef logic [ACC_W-1:0] acc_t;

    typedef enum logic [2:0] {
        ACCUMULATE,
        AVERAGE,     // load all eight sums
        WAIT_AVG,
        RATIO,       // load the four magnitude ratios
        WAIT_RATIO,
        SEND,
        HOLD         // waiting for out_ready
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/sample_counter.sv
`default_nettype none

module sample_counter #(
    parameter int CNT_W = coeff_pkg::CNT_W
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             take,
    input  logic             clear,
    input  logic [CNT_W-1:0] num_samples,
    output logic             last
);

    logic [CNT_W-1:0] count;  // samples taken so far in this frame

    // current sample completes the frame
    assign last = (count == num_samples - CNT_W'(1));

    always_ff @(posedge clk_in) begin
        if (rst_in || clear) begin
            count <= '0;
        end else if (take) begin
            count <= count + CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/stream_accumulator.sv
`default_nettype none

module stream_accumulator #(
    parameter int ACC_W = coeff_pkg::ACC_W
) (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  logic                          take,
    input  logic                          clear,
    input  logic [coeff_pkg::SAMPLE_W-1:0] a1_data,
    input  logic [coeff_pkg::SAMPLE_W-1:0] b1_data,
    input  logic [coeff_pkg::SAMPLE_W-1:0] a2_data,
    input  logic [coeff_pkg::SAMPLE_W-1:0] b2_data,
    output logic [ACC_W-1:0]               mag_sum   [coeff_pkg::NUM_CH],
    output logic [ACC_W-1:0]               phase_sum [coeff_pkg::NUM_CH]
);

    localparam int H = coeff_pkg::HALF_W;
    localparam int S = coeff_pkg::SAMPLE_W;

    logic [H-1:0] mag   [coeff_pkg::NUM_CH];  // a1 b1 a2 b2
    logic [H-1:0] phase [coeff_pkg::NUM_CH];
    logic [H-1:0] diff  [coeff_pkg::NUM_CH];  // s11 s12 s21 s22

    assign mag[0] = a1_data[H-1:0];
    assign mag[1] = b1_data[H-1:0];
    assign mag[2] = a2_data[H-1:0];
    assign mag[3] = b2_data[H-1:0];

    assign phase[0] = a1_data[S-1:H];
    assign phase[1] = b1_data[S-1:H];
    assign phase[2] = a2_data[S-1:H];
    assign phase[3] = b2_data[S-1:H];

    // differences wrap modulo 2^16
    assign diff[0] = phase[1] - phase[0];  // b1 - a1
    assign diff[1] = phase[1] - phase[2];  // b1 - a2
    assign diff[2] = phase[3] - phase[0];  // b2 - a1
    assign diff[3] = phase[3] - phase[2];  // b2 - a2

    always_ff @(posedge clk_in) begin
        if (rst_in || clear) begin
            for (int i = 0; i < coeff_pkg::NUM_CH; i++) begin
                mag_sum[i]   <= '0;
                phase_sum[i] <= '0;
            end
        end else if (take) begin
            for (int i = 0; i < coeff_pkg::NUM_CH; i++) begin
                mag_sum[i]   <= mag_sum[i] + ACC_W'(mag[i]);
                phase_sum[i] <= phase_sum[i] + ACC_W'(diff[i]);  // zero-extended
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/serial_divider.sv
`default_nettype none

module serial_divider #(
    parameter int WIDTH = coeff_pkg::ACC_W
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             start,
    input  logic [WIDTH-1:0] dividend,
    input  logic [WIDTH-1:0] divisor,
    output logic [WIDTH-1:0] quotient,
    output logic             done,
    output logic             div_zero
);

    localparam int STEP_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic              busy;
    logic [STEP_W-1:0] step;     // bits still to go after this one
    logic [WIDTH-1:0]  rem;      // partial remainder
    logic [WIDTH-1:0]  shift_q;  // dividend shifts out, quotient shifts in
    logic [WIDTH-1:0]  dvsr;
    logic [WIDTH:0]    trial;    // one extra bit so large divisors cannot overflow
    logic              fits;
    logic [WIDTH-1:0]  next_q;

    assign trial  = {rem, shift_q[WIDTH-1]};
    assign fits   = (trial >= {1'b0, dvsr});
    assign next_q = (shift_q << 1) | WIDTH'(fits);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy     <= 1'b0;
            step     <= '0;
            done     <= 1'b0;
            div_zero <= 1'b0;
        end else begin
            done     <= 1'b0;
            div_zero <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    step <= STEP_W'(WIDTH - 1);
                end
            end else if (step == '0) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                div_zero <= (dvsr == '0);  // quotient is all ones then
            end else begin
                step <= step - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!busy) begin
            if (start) begin
                rem     <= '0;
                shift_q <= dividend;
                dvsr    <= divisor;
            end
        end else begin
            // restore by keeping the shifted remainder when the divisor does not fit
            rem     <= fits ? WIDTH'(trial - {1'b0, dvsr}) : trial[WIDTH-1:0];
            shift_q <= next_q;
            if (step == '0) begin
                quotient <= next_q;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/coeff_ctrl.sv
`default_nettype none

module coeff_ctrl (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic                           last,
    output logic                           take,
    output logic                           clear,
    input  coeff_pkg::acc_t                mag_sum      [coeff_pkg::NUM_CH],
    input  coeff_pkg::acc_t                phase_sum    [coeff_pkg::NUM_CH],
    input  logic [coeff_pkg::CNT_W-1:0]    num_samples,
    output coeff_pkg::acc_t                div_dividend [coeff_pkg::NUM_DIV],
    output coeff_pkg::acc_t                div_divisor  [coeff_pkg::NUM_DIV],
    output logic                           div_start,
    input  coeff_pkg::acc_t                div_quotient [coeff_pkg::NUM_DIV],
    input  logic                           div_done,
    input  logic                           div_zero     [coeff_pkg::NUM_DIV],
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [coeff_pkg::SAMPLE_W-1:0] s11_data,
    output logic [coeff_pkg::SAMPLE_W-1:0] s12_data,
    output logic [coeff_pkg::SAMPLE_W-1:0] s21_data,
    output logic [coeff_pkg::SAMPLE_W-1:0] s22_data
);

    localparam int NCH = coeff_pkg::NUM_CH;
    localparam int H   = coeff_pkg::HALF_W;

    coeff_pkg::ctrl_state_t state;

    coeff_pkg::acc_t                avg_mag    [NCH];  // a1 b1 a2 b2
    logic [H-1:0]                   avg_phase  [NCH];
    logic [H-1:0]                   ratio      [NCH];
    logic [coeff_pkg::SAMPLE_W-1:0] coeff_word [NCH];

    assign in_ready = (state == coeff_pkg::ACCUMULATE);
    assign take     = in_valid && in_ready;
    assign clear    = (state == coeff_pkg::HOLD) && out_ready;  // on the transfer edge

    assign s11_data = coeff_word[0];
    assign s12_data = coeff_word[1];
    assign s21_data = coeff_word[2];
    assign s22_data = coeff_word[3];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= coeff_pkg::ACCUMULATE;
            div_start <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                coeff_pkg::ACCUMULATE: begin
                    if (take && last) begin
                        state <= coeff_pkg::AVERAGE;
                    end
                end
                coeff_pkg::AVERAGE: begin
                    div_start <= 1'b1;
                    state     <= coeff_pkg::WAIT_AVG;
                end
                coeff_pkg::WAIT_AVG: begin
                    if (div_done) begin
                        state <= coeff_pkg::RATIO;
                    end
                end
                coeff_pkg::RATIO: begin
                    div_start <= 1'b1;
                    state     <= coeff_pkg::WAIT_RATIO;
                end
                coeff_pkg::WAIT_RATIO: begin
                    if (div_done) begin
                        state <= coeff_pkg::SEND;
                    end
                end
                coeff_pkg::SEND: begin
                    out_valid <= 1'b1;
                    state     <= coeff_pkg::HOLD;
                end
                coeff_pkg::HOLD: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        state     <= coeff_pkg::ACCUMULATE;
                    end
                end
                default: state <= coeff_pkg::ACCUMULATE;
            endcase
        end
    end

    // operands for the dividers and the captured results
    always_ff @(posedge clk_in) begin
        case (state)
            coeff_pkg::AVERAGE: begin
                for (int i = 0; i < NCH; i++) begin
                    div_dividend[i]       <= phase_sum[i];
                    div_dividend[i + NCH] <= mag_sum[i];
                    div_divisor[i]        <= coeff_pkg::acc_t'(num_samples);
                    div_divisor[i + NCH]  <= coeff_pkg::acc_t'(num_samples);
                end
            end
            coeff_pkg::WAIT_AVG: begin
                if (div_done) begin
                    for (int i = 0; i < NCH; i++) begin
                        avg_phase[i] <= div_quotient[i][H-1:0];
                        avg_mag[i]   <= div_quotient[i + NCH];
                    end
                end
            end
            coeff_pkg::RATIO: begin
                // 4..7 keep their operands and just rerun
                div_dividend[0] <= avg_mag[1];  // b1 / a1
                div_divisor[0]  <= avg_mag[0];
                div_dividend[1] <= avg_mag[1];  // b1 / a2
                div_divisor[1]  <= avg_mag[2];
                div_dividend[2] <= avg_mag[3];  // b2 / a1
                div_divisor[2]  <= avg_mag[0];
                div_dividend[3] <= avg_mag[3];  // b2 / a2
                div_divisor[3]  <= avg_mag[2];
            end
            coeff_pkg::WAIT_RATIO: begin
                if (div_done) begin
                    for (int i = 0; i < NCH; i++) begin
                        ratio[i] <= div_zero[i] ? '0 : div_quotient[i][H-1:0];
                    end
                end
            end
            coeff_pkg::SEND: begin
                for (int i = 0; i < NCH; i++) begin
                    coeff_word[i] <= {avg_phase[i], ratio[i]};
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/coeff_averager.sv
`default_nettype none

module coeff_averager #(
    parameter int ACC_W = coeff_pkg::ACC_W,
    parameter int CNT_W = coeff_pkg::CNT_W
) (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic [CNT_W-1:0]               num_samples,  // nonzero
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [coeff_pkg::SAMPLE_W-1:0] a1_data,
    input  logic [coeff_pkg::SAMPLE_W-1:0] b1_data,
    input  logic [coeff_pkg::SAMPLE_W-1:0] a2_data,
    input  logic [coeff_pkg::SAMPLE_W-1:0] b2_data,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [coeff_pkg::SAMPLE_W-1:0] s11_data,
    output logic [coeff_pkg::SAMPLE_W-1:0] s12_data,
    output logic [coeff_pkg::SAMPLE_W-1:0] s21_data,
    output logic [coeff_pkg::SAMPLE_W-1:0] s22_data
);

    logic take;
    logic clear;
    logic last;

    logic [ACC_W-1:0] mag_sum   [coeff_pkg::NUM_CH];
    logic [ACC_W-1:0] phase_sum [coeff_pkg::NUM_CH];

    logic [ACC_W-1:0] div_dividend [coeff_pkg::NUM_DIV];
    logic [ACC_W-1:0] div_divisor  [coeff_pkg::NUM_DIV];
    logic [ACC_W-1:0] div_quotient [coeff_pkg::NUM_DIV];
    logic             div_start;
    logic             div_done     [coeff_pkg::NUM_DIV];  // all finish together
    logic             div_zero     [coeff_pkg::NUM_DIV];

    sample_counter #(.CNT_W(CNT_W)) u_counter (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .take        (take),
        .clear       (clear),
        .num_samples (num_samples),
        .last        (last)
    );

    stream_accumulator #(.ACC_W(ACC_W)) u_accum (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .take      (take),
        .clear     (clear),
        .a1_data   (a1_data),
        .b1_data   (b1_data),
        .a2_data   (a2_data),
        .b2_data   (b2_data),
        .mag_sum   (mag_sum),
        .phase_sum (phase_sum)
    );

    generate
        for (genvar g = 0; g < coeff_pkg::NUM_DIV; g++) begin : g_div
            serial_divider #(.WIDTH(ACC_W)) u_div (
                .clk_in   (clk_in),
                .rst_in   (rst_in),
                .start    (div_start),
                .dividend (div_dividend[g]),
                .divisor  (div_divisor[g]),
                .quotient (div_quotient[g]),
                .done     (div_done[g]),
                .div_zero (div_zero[g])
            );
        end
    endgenerate

    coeff_ctrl u_ctrl (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .last         (last),
        .take         (take),
        .clear        (clear),
        .mag_sum      (mag_sum),
        .phase_sum    (phase_sum),
        .num_samples  (num_samples),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_start    (div_start),
        .div_quotient (div_quotient),
        .div_done     (div_done[0]),  // divider 0 stands for the group
        .div_zero     (div_zero),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .s11_data     (s11_data),
        .s12_data     (s12_data),
        .s21_data     (s21_data),
        .s22_data     (s22_data)
    );

endmodule

`default_nettype wire

// File: dv/coeff_model.svh
`ifndef COEFF_MODEL_SVH
`define COEFF_MODEL_SVH

`default_nettype none

localparam int MAX_N = 16;  // longest frame the testbench sends

typedef logic [31:0] frame_t [MAX_N];

// next state of the 32-bit LCG
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// floor mean of the magnitude halves
function automatic logic [31:0] mean_mag(input frame_t x, input int n);
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < n; k++) begin
        sum = sum + {16'h0000, x[k][15:0]};
    end
    return sum / 32'(n);
endfunction

// floor mean of the phase difference y - x, each term wrapped to 16 bits
function automatic logic [31:0] mean_phase(input frame_t y, input frame_t x, input int n);
    logic [31:0] sum;
    logic [15:0] d;
    sum = '0;
    for (int k = 0; k < n; k++) begin
        d   = y[k][31:16] - x[k][31:16];
        sum = sum + {16'h0000, d};
    end
    return sum / 32'(n);
endfunction

// integer ratio, zero when the divisor mean is zero
function automatic logic [15:0] mag_ratio(input logic [31:0] num, input logic [31:0] den);
    logic [31:0] q;
    if (den == '0) begin
        return '0;
    end
    q = num / den;
    return q[15:0];
endfunction

function automatic logic [31:0] pack_word(input logic [31:0] phase_avg, input logic [15:0] ratio);
    return {phase_avg[15:0], ratio};
endfunction

`default_nettype wire

`endif

// File: dv/coeff_averager_tb.sv
`include "coeff_model.svh"

`default_nettype none

module coeff_averager_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACC_W      = 32;
    localparam int CNT_W      = 16;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_FRAMES = 5;
    localparam int FRAME_LEN [NUM_FRAMES] = '{4, 4, 1, 7, 3};

    logic             clk_in;
    logic             rst_in;
    logic [CNT_W-1:0] num_samples;
    logic             in_valid;
    logic             in_ready;
    logic [31:0]      a1_data;
    logic [31:0]      b1_data;
    logic [31:0]      a2_data;
    logic [31:0]      b2_data;
    logic             out_valid;
    logic             out_ready;
    logic [31:0]      s11_data;
    logic [31:0]      s12_data;
    logic [31:0]      s21_data;
    logic [31:0]      s22_data;

    logic [31:0]      exp_word [4];  // s11 s12 s21 s22
    logic             zero_frame;    // a1 magnitudes all zero
    logic             pending;       // last sample taken, result not yet transferred
    logic [CNT_W-1:0] taken;
    logic [31:0]      seed;
    frame_t           a1_s;
    frame_t           b1_s;
    frame_t           a2_s;
    frame_t           b2_s;

    coeff_averager #(.ACC_W(ACC_W), .CNT_W(CNT_W)) UUT (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .num_samples (num_samples),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .a1_data     (a1_data),
        .b1_data     (b1_data),
        .a2_data     (a2_data),
        .b2_data     (b2_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .s11_data    (s11_data),
        .s12_data    (s12_data),
        .s21_data    (s21_data),
        .s22_data    (s22_data)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [15:0] rand16();
        seed = lcg_next(seed);
        return seed[31:16];  // upper bits, the low ones repeat quickly
    endfunction

    // frame bookkeeping seen from the bus side
    always @(posedge clk_in) begin
        if (rst_in) begin
            pending <= 1'b0;
            taken   <= '0;
        end else if (out_valid && out_ready) begin
            pending <= 1'b0;
        end else if (in_valid && in_ready) begin
            if (taken == num_samples - CNT_W'(1)) begin
                pending <= 1'b1;
                taken   <= '0;
            end else begin
                taken <= taken + CNT_W'(1);
            end
        end
    end

    reset_idle: assert property (@(posedge clk_in) $fell(rst_in) |-> !out_valid && in_ready)
        else fail_run($sformatf("[ERROR] %0t: not idle after reset", $time));

    words_match: assert property (@(posedge clk_in) disable iff (rst_in)
        out_valid |-> s11_data == exp_word[0] && s12_data == exp_word[1]
            && s21_data == exp_word[2] && s22_data == exp_word[3])
        else fail_run($sformatf("[ERROR] %0t: words %h %h %h %h, expected %h %h %h %h",
            $time, s11_data, s12_data, s21_data, s22_data,
            exp_word[0], exp_word[1], exp_word[2], exp_word[3]));

    zero_ratio: assert property (@(posedge clk_in) disable iff (rst_in)
        out_valid && zero_frame |-> s11_data[15:0] == '0 && s21_data[15:0] == '0)
        else fail_run($sformatf("[ERROR] %0t: ratio not zero for zero a1", $time));

    hold_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        out_valid && !out_ready |=> out_valid && $stable(s11_data) && $stable(s12_data)
            && $stable(s21_data) && $stable(s22_data))
        else fail_run($sformatf("[ERROR] %0t: output changed under back-pressure", $time));

    busy_not_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        pending |-> !in_ready)
        else fail_run($sformatf("[ERROR] %0t: in_ready high before transfer", $time));

    valid_when_pending: assert property (@(posedge clk_in) disable iff (rst_in)
        out_valid |-> pending)
        else fail_run($sformatf("[ERROR] %0t: out_valid without a frame", $time));

    // one sample, held until the DUT takes it
    task automatic send_sample(input logic [31:0] a1, input logic [31:0] b1,
                               input logic [31:0] a2, input logic [31:0] b2);
        in_valid <= 1'b1;
        a1_data  <= a1;
        b1_data  <= b1;
        a2_data  <= a2;
        b2_data  <= b2;
        @(posedge clk_in);
        while (!in_ready) @(posedge clk_in);
    endtask

    // negative stall raises out_ready before out_valid
    task automatic collect(input int stall);
        if (stall < 0) out_ready <= 1'b1;
        while (!out_valid) @(posedge clk_in);
        repeat (stall > 0 ? stall : 0) @(posedge clk_in);
        out_ready <= 1'b1;
        @(posedge clk_in);  // transfer edge
        out_ready <= 1'b0;
    endtask

    task automatic run_frame(input int n, input bit zero_a1, input int stall);
        logic [31:0] avg [4];  // magnitude means a1 b1 a2 b2
        logic [31:0] ph  [4];  // phase means s11 s12 s21 s22
        for (int k = 0; k < n; k++) begin
            a1_s[k] = {rand16(), rand16()};
            b1_s[k] = {rand16(), rand16()};
            a2_s[k] = {rand16(), rand16()};
            b2_s[k] = {rand16(), rand16()};
            if (zero_a1) a1_s[k][15:0] = '0;
        end
        avg[0] = mean_mag(a1_s, n);
        avg[1] = mean_mag(b1_s, n);
        avg[2] = mean_mag(a2_s, n);
        avg[3] = mean_mag(b2_s, n);
        ph[0]  = mean_phase(b1_s, a1_s, n);
        ph[1]  = mean_phase(b1_s, a2_s, n);
        ph[2]  = mean_phase(b2_s, a1_s, n);
        ph[3]  = mean_phase(b2_s, a2_s, n);
        exp_word[0] <= pack_word(ph[0], mag_ratio(avg[1], avg[0]));
        exp_word[1] <= pack_word(ph[1], mag_ratio(avg[1], avg[2]));
        exp_word[2] <= pack_word(ph[2], mag_ratio(avg[3], avg[0]));
        exp_word[3] <= pack_word(ph[3], mag_ratio(avg[3], avg[2]));
        zero_frame  <= zero_a1;
        num_samples <= CNT_W'(n);
        for (int k = 0; k < n; k++) begin
            send_sample(a1_s[k], b1_s[k], a2_s[k], b2_s[k]);
        end
        in_valid <= 1'b0;
        collect(stall);
    endtask

    initial begin : watchdog
        int total;
        total = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            total += FRAME_LEN[f] + 2 * ACC_W + 10;
        end
        #(2 * total * CLK_PERIOD);
        fail_run($sformatf("timeout: no finished run after %0d cycles", 2 * total));
    end

    initial begin
        int stall;
        seed        = 32'd26;
        rst_in      = 1'b1;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        num_samples = CNT_W'(1);
        a1_data     = '0;
        b1_data     = '0;
        a2_data     = '0;
        b2_data     = '0;
        zero_frame  = 1'b0;
        for (int i = 0; i < 4; i++) exp_word[i] = '0;
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;
        @(posedge clk_in);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f == NUM_FRAMES - 1) stall = -1;  // ready waiting ahead of the result
            else if (f == 1) stall = 0;
            else stall = 1 + int'(rand16() % 16'd8);
            run_frame(FRAME_LEN[f], f == 1, stall);
        end
        repeat (2) @(posedge clk_in);
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+dv
rtl/coeff_pkg.sv
rtl/sample_counter.sv
rtl/stream_accumulator.sv
rtl/serial_divider.sv
rtl/coeff_ctrl.sv
rtl/coeff_averager.sv
dv/coeff_averager_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

TOP=coeff_averager_tb
OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f build.f --top-module "$TOP" -Mdir "$OBJ" -o "V$TOP"

# tee keeps the pipeline going so the log is always searched
"./$OBJ/V$TOP" 2>&1 | tee "$LOG"

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
